//--- verilog/tx_shaping_pkg.sv
package tx_shaping_pkg;

    // Datapath widths
    localparam int SYM_W    = 4;
    localparam int COEF_W   = 8;
    localparam int PROD_W   = SYM_W + COEF_W;
    localparam int ACC_W    = 16;
    localparam int DAC_W    = 10;
    localparam int RATE_W   = 4;

    // Filter size and coefficient addressing
    localparam int NUM_TAPS = 16;
    localparam int ADDR_W   = 4;

    // DAC word is accumulator bits 15 down to 6
    localparam int OUT_SHIFT = 6;

    // Pipeline depths
    localparam int FIR_LAT     = 3;
    localparam int FILL_CYCLES = NUM_TAPS - 1 + FIR_LAT;
    localparam int FILL_W      = $clog2(FILL_CYCLES + 1);

    typedef logic signed [SYM_W-1:0]  sym_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // One signed coefficient per tap where index 0 multiplies the newest sample
    typedef coef_t [NUM_TAPS-1:0] coeff_vec_t;

endpackage

//--- verilog/reset_sync.sv
module reset_sync (
    input  logic clk,
    input  logic rst_n_i,
    output logic rst_n_sync_o
);

    logic meta_q;
    logic sync_q;

    // Assert at once, release after two clock edges
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_q <= 1'b0;
            sync_q <= 1'b0;
        end else begin
            meta_q <= 1'b1;
            sync_q <= meta_q;
        end
    end

    assign rst_n_sync_o = sync_q;

endmodule

//--- verilog/upsampler.sv
module upsampler (
    input  logic                              clk,
    input  logic                              rst_n_sync_wire,
    input  logic [tx_shaping_pkg::RATE_W-1:0] sample_rate_i,
    input  logic                              new_symbol_i,
    input  tx_shaping_pkg::sym_t              sym_i_i,
    input  tx_shaping_pkg::sym_t              sym_q_i,
    output tx_shaping_pkg::sym_t              samp_i_o,
    output tx_shaping_pkg::sym_t              samp_q_o,
    output logic                              sym_emit_o
);
    import tx_shaping_pkg::*;

    logic [RATE_W-1:0] phase_q;
    logic [RATE_W-1:0] rate_q;
    logic [RATE_W-1:0] rate_eff;
    logic              phase_wrap;
    logic              pending_q;
    sym_t              hold_i_q;
    sym_t              hold_q_q;

    // A rate of zero behaves as one
    assign rate_eff   = (sample_rate_i == '0) ? RATE_W'(1) : sample_rate_i;
    assign phase_wrap = (phase_q == rate_q - 1'b1);

    // Free phase counter that takes a new rate only on wrap
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            phase_q <= '0;
            rate_q  <= RATE_W'(1);
        end else if (phase_wrap) begin
            phase_q <= '0;
            rate_q  <= rate_eff;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (new_symbol_i) begin
            hold_i_q <= sym_i_i;
            hold_q_q <= sym_q_i;
        end
    end

    // A new arrival wins over the clear at phase 0
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            pending_q <= 1'b0;
        end else if (new_symbol_i) begin
            pending_q <= 1'b1;
        end else if (phase_q == '0) begin
            pending_q <= 1'b0;
        end
    end

    // Zeros on stuffed phases and on underrun
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            samp_i_o   <= '0;
            samp_q_o   <= '0;
            sym_emit_o <= 1'b0;
        end else if (phase_q == '0 && pending_q) begin
            samp_i_o   <= hold_i_q;
            samp_q_o   <= hold_q_q;
            sym_emit_o <= 1'b1;
        end else begin
            samp_i_o   <= '0;
            samp_q_o   <= '0;
            sym_emit_o <= 1'b0;
        end
    end

    // Phase stays below the rate in use
    assert property (@(posedge clk) disable iff (!rst_n_sync_wire)
        phase_q < rate_q);

endmodule

//--- verilog/coeff_bank.sv
module coeff_bank (
    input  logic                              clk,
    input  logic                              rst_n_sync_wire,
    input  logic                              coeff_write_i,
    input  logic [tx_shaping_pkg::ADDR_W-1:0] coeff_addr_i,
    input  tx_shaping_pkg::coef_t             coeff_data_i,
    output tx_shaping_pkg::coeff_vec_t        coeffs_o,
    output tx_shaping_pkg::coef_t             coeff_rdata_o
);
    import tx_shaping_pkg::*;

    coeff_vec_t coeffs_q;

    // Host writes land in the shared bank
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            coeffs_q <= '0;
        end else if (coeff_write_i) begin
            coeffs_q[coeff_addr_i] <= coeff_data_i;
        end
    end

    // Registered read-back of the addressed entry
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            coeff_rdata_o <= '0;
        end else begin
            coeff_rdata_o <= coeffs_q[coeff_addr_i];
        end
    end

    // Both filters see the whole bank
    assign coeffs_o = coeffs_q;

    assert property (@(posedge clk) disable iff (!rst_n_sync_wire)
        coeff_write_i |-> !$isunknown(coeff_addr_i));

endmodule

//--- verilog/fir_filter.sv
module fir_filter (
    input  logic                       clk,
    input  logic                       rst_n_sync_wire,
    input  tx_shaping_pkg::sym_t       sample_i,
    input  tx_shaping_pkg::coeff_vec_t coeffs_i,
    output tx_shaping_pkg::acc_t       fir_o
);
    import tx_shaping_pkg::*;

    localparam int NUM_GRP = 4;
    localparam int GRP_SZ  = NUM_TAPS / NUM_GRP;

    sym_t  dly_q  [1:NUM_TAPS-1];
    sym_t  tap    [NUM_TAPS];
    prod_t prod_q [NUM_TAPS];
    acc_t  psum_q [NUM_GRP];
    acc_t  grp_sum[NUM_GRP];
    acc_t  total;

    // Tap 0 is the incoming sample, older samples sit in the delay line
    always_comb begin
        tap[0] = sample_i;
        for (int k = 1; k < NUM_TAPS; k++) begin
            tap[k] = dly_q[k];
        end
    end

    // Group and final adder trees
    always_comb begin
        total = '0;
        for (int g = 0; g < NUM_GRP; g++) begin
            grp_sum[g] = '0;
            for (int j = 0; j < GRP_SZ; j++) begin
                grp_sum[g] = grp_sum[g] + acc_t'(prod_q[g*GRP_SZ+j]);
            end
            total = total + psum_q[g];
        end
    end

    // Stage 1 delay line and products, stage 2 partial sums, stage 3 total
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            for (int k = 1; k < NUM_TAPS; k++) begin
                dly_q[k] <= '0;
            end
            for (int k = 0; k < NUM_TAPS; k++) begin
                prod_q[k] <= '0;
            end
            for (int g = 0; g < NUM_GRP; g++) begin
                psum_q[g] <= '0;
            end
            fir_o <= '0;
        end else begin
            dly_q[1] <= sample_i;
            for (int k = 2; k < NUM_TAPS; k++) begin
                dly_q[k] <= dly_q[k-1];
            end
            for (int k = 0; k < NUM_TAPS; k++) begin
                prod_q[k] <= tap[k] * coeffs_i[k];
            end
            for (int g = 0; g < NUM_GRP; g++) begin
                psum_q[g] <= grp_sum[g];
            end
            fir_o <= total;
        end
    end

endmodule

//--- verilog/dac_output_stage.sv
module dac_output_stage (
    input  logic                             clk,
    input  logic                             rst_n_sync_wire,
    input  logic                             sym_emit_i,
    input  tx_shaping_pkg::acc_t             fir_i_i,
    input  tx_shaping_pkg::acc_t             fir_q_i,
    output logic [tx_shaping_pkg::DAC_W-1:0] dac_i_o,
    output logic [tx_shaping_pkg::DAC_W-1:0] dac_q_o,
    output logic                             data_out_valid_o
);
    import tx_shaping_pkg::*;

    logic [FILL_W-1:0] fill_cnt_q;
    logic              fill_run;
    acc_t              shr_i;
    acc_t              shr_q;

    // Count from the first emission until the pipeline is full
    assign fill_run = (fill_cnt_q != '0 || sym_emit_i) && (fill_cnt_q != FILL_W'(FILL_CYCLES));

    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            fill_cnt_q       <= '0;
            data_out_valid_o <= 1'b0;
        end else begin
            if (fill_run) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
            end
            // Sticky once the count reaches the fill depth
            if (fill_cnt_q == FILL_W'(FILL_CYCLES - 1)) begin
                data_out_valid_o <= 1'b1;
            end
        end
    end

    // Arithmetic shift truncates toward negative infinity
    assign shr_i = fir_i_i >>> OUT_SHIFT;
    assign shr_q = fir_q_i >>> OUT_SHIFT;

    assign dac_i_o = data_out_valid_o ? shr_i[DAC_W-1:0] : '0;
    assign dac_q_o = data_out_valid_o ? shr_q[DAC_W-1:0] : '0;

    // Valid tracks the saturated fill count
    assert property (@(posedge clk) disable iff (!rst_n_sync_wire)
        data_out_valid_o == (fill_cnt_q == FILL_W'(FILL_CYCLES)));

endmodule

//--- verilog/pulse_shaping_tx.sv
module pulse_shaping_tx (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic        [tx_shaping_pkg::RATE_W-1:0] sample_rate_i,
    input  logic signed [tx_shaping_pkg::SYM_W-1:0]  sym_i_i,
    input  logic signed [tx_shaping_pkg::SYM_W-1:0]  sym_q_i,
    input  logic                                     new_symbol_i,
    input  logic                                     coeff_write_i,
    input  logic        [tx_shaping_pkg::ADDR_W-1:0] coeff_addr_i,
    input  logic signed [tx_shaping_pkg::COEF_W-1:0] coeff_data_i,
    output logic        [tx_shaping_pkg::DAC_W-1:0]  dac_i_o,
    output logic        [tx_shaping_pkg::DAC_W-1:0]  dac_q_o,
    output logic                                     data_out_valid_o,
    output logic signed [tx_shaping_pkg::COEF_W-1:0] coeff_rdata_o
);
    import tx_shaping_pkg::*;

    logic       rst_n_sync_wire;
    sym_t       samp_i;
    sym_t       samp_q;
    logic       sym_emit;
    coeff_vec_t coeffs;
    acc_t       fir_i;
    acc_t       fir_q;

    reset_sync u_reset_sync (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rst_n_sync_o (rst_n_sync_wire)
    );

    upsampler u_upsampler (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .sample_rate_i   (sample_rate_i),
        .new_symbol_i    (new_symbol_i),
        .sym_i_i         (sym_i_i),
        .sym_q_i         (sym_q_i),
        .samp_i_o        (samp_i),
        .samp_q_o        (samp_q),
        .sym_emit_o      (sym_emit)
    );

    // One coefficient bank shared by both channels
    coeff_bank u_coeff_bank (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .coeff_write_i   (coeff_write_i),
        .coeff_addr_i    (coeff_addr_i),
        .coeff_data_i    (coeff_data_i),
        .coeffs_o        (coeffs),
        .coeff_rdata_o   (coeff_rdata_o)
    );

    fir_filter i_fir (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .sample_i        (samp_i),
        .coeffs_i        (coeffs),
        .fir_o           (fir_i)
    );

    fir_filter q_fir (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .sample_i        (samp_q),
        .coeffs_i        (coeffs),
        .fir_o           (fir_q)
    );

    dac_output_stage u_dac_output_stage (
        .clk              (clk),
        .rst_n_sync_wire  (rst_n_sync_wire),
        .sym_emit_i       (sym_emit),
        .fir_i_i          (fir_i),
        .fir_q_i          (fir_q),
        .dac_i_o          (dac_i_o),
        .dac_q_o          (dac_q_o),
        .data_out_valid_o (data_out_valid_o)
    );

endmodule

//--- verif/clock_gen.sv
module clock_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        clk_o = 1'b0;
    end

    always #4 clk_o = ~clk_o;

endmodule

//--- verif/tb_pulse_shaping_tx.sv
module tb_pulse_shaping_tx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYC = 256;

    logic              clk;
    logic              rst_n_i;
    logic        [3:0] sample_rate_i;
    logic signed [3:0] sym_i_i;
    logic signed [3:0] sym_q_i;
    logic              new_symbol_i;
    logic              coeff_write_i;
    logic        [3:0] coeff_addr_i;
    logic signed [7:0] coeff_data_i;
    logic        [9:0] dac_i_o;
    logic        [9:0] dac_q_o;
    logic              data_out_valid_o;
    logic signed [7:0] coeff_rdata_o;

    // Expected DAC words and symbol pulses indexed by the edge count since reset
    logic [9:0] exp_i [MAX_CYC];
    logic [9:0] exp_q [MAX_CYC];
    bit         sym_flag [MAX_CYC];
    int         sym_iv [MAX_CYC];
    int         sym_qv [MAX_CYC];

    int              cyc;
    int              valid_from;
    int              test_errs;
    int              total_errs;
    int              tests_run;
    int              tests_failed;
    int              total_cycles;
    int              fd;
    bit              test_open;
    logic [8*32-1:0] test_name;

    clock_gen clk_gen_i (.clk_o(clk));

    pulse_shaping_tx dut_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .sample_rate_i    (sample_rate_i),
        .sym_i_i          (sym_i_i),
        .sym_q_i          (sym_q_i),
        .new_symbol_i     (new_symbol_i),
        .coeff_write_i    (coeff_write_i),
        .coeff_addr_i     (coeff_addr_i),
        .coeff_data_i     (coeff_data_i),
        .dac_i_o          (dac_i_o),
        .dac_q_o          (dac_q_o),
        .data_out_valid_o (data_out_valid_o),
        .coeff_rdata_o    (coeff_rdata_o)
    );

    // One rising edge and back to the falling edge where inputs change
    task automatic step();
        @(posedge clk);
        @(negedge clk);
        cyc++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic clear_expect();
        for (int k = 0; k < MAX_CYC; k++) begin
            exp_i[k]    = '0;
            exp_q[k]    = '0;
            sym_flag[k] = 1'b0;
            sym_iv[k]   = 0;
            sym_qv[k]   = 0;
        end
        valid_from = MAX_CYC;
    endtask

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;
        // Synchronizer releases after two edges and edge 0 is the first active one
        repeat (2) @(negedge clk);
        cyc = 0;
        check_value("dac_i_o", dac_i_o, 0);
        check_value("dac_q_o", dac_q_o, 0);
        check_value("data_out_valid_o", data_out_valid_o, 0);
    endtask

    task automatic read_coeff(input int addr, input int data);
        coeff_addr_i = 4'(addr);
        step();
        check_value("coeff_rdata_o", coeff_rdata_o, data);
    endtask

    task automatic write_coeff(input int addr, input int data);
        coeff_addr_i  = 4'(addr);
        coeff_data_i  = 8'(data);
        coeff_write_i = 1'b1;
        step();
        coeff_write_i = 1'b0;
        step();
        check_value("coeff_rdata_o", coeff_rdata_o, data);
    endtask

    task automatic run_stream(input int end_cyc);
        int c;
        while (cyc < end_cyc) begin
            c = cyc;
            new_symbol_i = sym_flag[c];
            sym_i_i      = 4'(sym_iv[c]);
            sym_q_i      = 4'(sym_qv[c]);
            step();
            check_value("dac_i_o", dac_i_o, exp_i[c]);
            check_value("dac_q_o", dac_q_o, exp_q[c]);
            check_value("data_out_valid_o", data_out_valid_o, c >= valid_from);
        end
        new_symbol_i = 1'b0;
    endtask

    task automatic finish_test();
        total_errs += test_errs;
        if (test_open) begin
            tests_run++;
            if (test_errs == 0) begin
                $display("Test %0s passed", test_name);
            end else begin
                $display("Test %0s failed with %0d errors", test_name, test_errs);
                tests_failed++;
            end
        end
        test_errs = 0;
    endtask

    initial begin
        int              code;
        int              a;
        int              d;
        int              n;
        int              v;
        logic [8*8-1:0]   tok;
        logic [8*160-1:0] line;
        rst_n_i       = 1'b0;
        sample_rate_i = '0;
        sym_i_i       = '0;
        sym_q_i       = '0;
        new_symbol_i  = 1'b0;
        coeff_write_i = 1'b0;
        coeff_addr_i  = '0;
        coeff_data_i  = '0;
        cyc           = 0;
        test_errs     = 0;
        total_errs    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        total_cycles  = 0;
        test_open     = 1'b0;
        clear_expect();
        fd = $fopen("verif/tx_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file verif/tx_vectors.txt");
            total_errs = 1;
        end else begin
            @(negedge clk);
            while ($fscanf(fd, " %s", tok) == 1) begin
                case (tok)
                    "#": code = $fgets(line, fd);
                    "N": code = $fscanf(fd, " %d", total_cycles);
                    "T": begin
                        finish_test();
                        code      = $fscanf(fd, " %s", test_name);
                        test_errs = 0;
                        test_open = 1'b1;
                        clear_expect();
                    end
                    "L": begin
                        code          = $fscanf(fd, " %d", a);
                        sample_rate_i = 4'(a);
                    end
                    "R": apply_reset();
                    "C": begin
                        for (int k = 0; k < 16; k++) begin
                            read_coeff(k, 0);
                        end
                    end
                    "W": begin
                        code = $fscanf(fd, " %d %d", a, d);
                        write_coeff(a, d);
                    end
                    "K": begin
                        code = $fscanf(fd, " %d %d", a, d);
                        read_coeff(a, d);
                    end
                    "S": begin
                        code        = $fscanf(fd, " %d %d %d", a, d, v);
                        sym_flag[a] = 1'b1;
                        sym_iv[a]   = d;
                        sym_qv[a]   = v;
                    end
                    "V": code = $fscanf(fd, " %d", valid_from);
                    "I", "Q": begin
                        code = $fscanf(fd, " %d %d", a, n);
                        for (int j = 0; j < n; j++) begin
                            code = $fscanf(fd, " %h", v);
                            if (tok == "I") begin
                                exp_i[a+j] = 10'(v);
                            end else begin
                                exp_q[a+j] = 10'(v);
                            end
                        end
                    end
                    "G": begin
                        code = $fscanf(fd, " %d", a);
                        run_stream(a);
                    end
                    default: begin
                        $display("Unknown command %0s in the vector file", tok);
                        test_errs++;
                    end
                endcase
            end
            finish_test();
            $fclose(fd);
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (tests_run > 0 && tests_failed == 0 && total_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Limit taken from the cycle count declared in the vector file
    initial begin
        wait (total_cycles > 0);
        #((total_cycles + 200) * 8);
        $display("Run timed out after %0d cycles", total_cycles + 200);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verif/tx_vectors.txt
# N cycles | T name | L rate | R reset | C all-zero readback | W/K addr data
# S cycle sym_i sym_q | V valid_cycle | I/Q first_cycle count hex_words | G end_cycle
N 240
T reset
L 1
R
C
T readback
R
W 0 5
W 7 -100
W 15 127
W 9 -128
K 0 5
T impulse_l4
L 4
R
W 0 64
W 1 32
W 2 -40
W 3 16
S 8 0 0
S 30 5 0
V 27
I 36 4 005 002 3fc 001
G 56
T stuff_l2
L 2
R
W 0 64
W 1 32
W 3 -64
S 6 0 0
S 26 3 -2
S 28 -4 1
S 32 2 5
V 25
I 30 10 003 001 3fc 3fb 000 004 002 001 000 3fe
Q 30 10 3fe 3ff 001 002 000 3ff 005 002 000 3fb
G 46
T stuff_l5
L 5
R
W 0 -64
W 2 48
W 5 64
S 7 0 0
S 28 7 -8
S 38 -5 3
V 29
I 34 16 3f9 000 005 000 000 007 000 000 000 000 005 000 3fc 000 000 3fb
Q 34 16 008 000 3fa 000 000 3f8 000 000 000 000 3fd 000 002 000 000 003
G 56

//--- pulse_shaping_tx.f
verilog/tx_shaping_pkg.sv
verilog/reset_sync.sv
verilog/upsampler.sv
verilog/coeff_bank.sv
verilog/fir_filter.sv
verilog/dac_output_stage.sv
verilog/pulse_shaping_tx.sv
verif/clock_gen.sv
verif/tb_pulse_shaping_tx.sv

//--- Makefile
TB_TOP = tb_pulse_shaping_tx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		--top-module pulse_shaping_tx -f pulse_shaping_tx.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TB_TOP) -f pulse_shaping_tx.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
